/* src/dm_sba_pkg.sv */
// shared types for the SBA block; only 32-bit word accesses, local SRAM of MEM_WORDS words
package dm_sba_pkg;

   // DMI and bus widths
   localparam int DMI_ADDR_W = 7;
   localparam int DATA_W = 32;

   // local SRAM geometry, byte addresses below MEM_BYTES are valid
   localparam int MEM_WORDS = 256;
   localparam int MEM_AW = 8;
   localparam int MEM_BYTES = MEM_WORDS * 4;

   // sbaccess code for 32-bit accesses, the only size served
   localparam logic [2:0] SBACCESS_32 = 3'd2;

   // lowest SBCS bit held in sbcs_t (sberror sits at 14:12)
   localparam int SBCS_LSB = 12;

   // DMI register map, anything else reads zero
   typedef enum logic [DMI_ADDR_W-1:0] {
      DMI_DMCONTROL  = 7'h10,
      DMI_SBCS       = 7'h38,
      DMI_SBADDRESS0 = 7'h39,
      DMI_SBDATA0    = 7'h3C
   } dmi_reg_e;

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      CAPTURE
   } sba_state_e;

   typedef enum logic [2:0] {
      ERR_NONE    = 3'd0,
      ERR_BADADDR = 3'd2,
      ERR_ALIGN   = 3'd3,
      ERR_SIZE    = 3'd4
   } sb_err_e;

   // one DMI request, 40 bits
   typedef struct packed {
      logic [DMI_ADDR_W-1:0] addr;
      logic                  we;
      logic [DATA_W-1:0]     wdata;
   } dmi_req_t;

   // SBCS fields in register order from bit 22 down to bit 12
   typedef struct packed {
      logic       sbbusyerror;
      logic       sbbusy;
      logic       sbreadonaddr;
      logic [2:0] sbaccess;
      logic       sbautoincrement;
      logic       sbreadondata;
      sb_err_e    sberror;
   } sbcs_t;

   localparam sbcs_t SBCS_RST = '{
      sbbusyerror:     1'b0,
      sbbusy:          1'b0,
      sbreadonaddr:    1'b0,
      sbaccess:        SBACCESS_32,
      sbautoincrement: 1'b0,
      sbreadondata:    1'b0,
      sberror:         ERR_NONE
   };

   // SRAM port request, 41 bits
   typedef struct packed {
      logic [MEM_AW-1:0] idx;
      logic              we;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   // access trigger from the register file to the sequencer
   typedef struct packed {
      logic start;
      logic write;
   } sba_cmd_t;

endpackage

/* src/sba_sram.sv */
// single-port word memory, no reset and no init; read data appears one cycle after the request
`timescale 1ns/1ns

module sba_sram (
   input  logic                           clk_sys,
   input  dm_sba_pkg::mem_req_t           mem_req_i,
   input  logic                           mem_valid_i,
   output logic [dm_sba_pkg::DATA_W-1:0]  rdata_o
);

   logic [dm_sba_pkg::DATA_W-1:0] mem_q [dm_sba_pkg::MEM_WORDS];
   logic [dm_sba_pkg::DATA_W-1:0] rdata_q;

   // write or read, never both in one cycle
   always_ff @(posedge clk_sys) begin
      if (mem_valid_i) begin
         if (mem_req_i.we) begin
            mem_q[mem_req_i.idx] <= mem_req_i.wdata;
         end else begin
            rdata_q <= mem_q[mem_req_i.idx];
         end
      end
   end

   // rdata keeps the last read while idle
   assign rdata_o = rdata_q;

endmodule

/* src/sba_addr_counter.sv */
// SBAddress0 holder; only byte addresses below MEM_BYTES and word aligned are accepted
`timescale 1ns/1ns

module sba_addr_counter (
   input  logic                           clk_sys,
   input  logic                           reset_i,
   input  logic                           load_i,
   input  logic [dm_sba_pkg::DATA_W-1:0]  load_data_i,
   input  logic                           step_i,
   input  logic                           autoinc_i,
   output logic [dm_sba_pkg::DATA_W-1:0]  addr_o,
   output logic [dm_sba_pkg::MEM_AW-1:0]  word_idx_o,
   output dm_sba_pkg::sb_err_e            addr_err_o
);

   logic [dm_sba_pkg::DATA_W-1:0] addr_q;

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         addr_q <= '0;
      end else if (load_i) begin
         addr_q <= load_data_i;
      end else if (step_i && autoinc_i) begin
         // one word per finished access
         addr_q <= addr_q + dm_sba_pkg::DATA_W'(4);
      end
   end

   // misalignment wins over range
   always_comb begin
      if (addr_q[1:0] != 2'b00) begin
         addr_err_o = dm_sba_pkg::ERR_ALIGN;
      end else if (addr_q >= dm_sba_pkg::DATA_W'(dm_sba_pkg::MEM_BYTES)) begin
         addr_err_o = dm_sba_pkg::ERR_BADADDR;
      end else begin
         addr_err_o = dm_sba_pkg::ERR_NONE;
      end
   end

   assign addr_o     = addr_q;
   assign word_idx_o = addr_q[dm_sba_pkg::MEM_AW+1:2];

   // address writes are refused while an access is in flight
   a_no_load_on_step: assert property (@(posedge clk_sys) disable iff (reset_i)
      !(load_i && step_i));

endmodule

/* src/sba_fsm.sv */
// one bus access at a time; size and address faults are reported without touching memory
`timescale 1ns/1ns

module sba_fsm (
   input  logic                           clk_sys,
   input  logic                           reset_i,
   input  dm_sba_pkg::sba_cmd_t           sba_cmd_i,
   input  logic [2:0]                     sbaccess_i,
   input  dm_sba_pkg::sb_err_e            addr_err_i,
   input  logic [dm_sba_pkg::MEM_AW-1:0]  word_idx_i,
   input  logic [dm_sba_pkg::DATA_W-1:0]  wdata_i,
   output dm_sba_pkg::mem_req_t           mem_req_o,
   output logic                           busy_o,
   output logic                           access_done_o,
   output logic                           err_valid_o,
   output dm_sba_pkg::sb_err_e            err_code_o
);

   dm_sba_pkg::sba_state_e state_q;
   dm_sba_pkg::sba_state_e state_d;
   dm_sba_pkg::sb_err_e    start_err;
   logic                   write_q;
   logic                   accept;

   // size is checked first, then the counter's address verdict
   always_comb begin
      if (sbaccess_i != dm_sba_pkg::SBACCESS_32) begin
         start_err = dm_sba_pkg::ERR_SIZE;
      end else begin
         start_err = addr_err_i;
      end
   end

   assign accept = sba_cmd_i.start & (state_q == dm_sba_pkg::IDLE);

   // error is flagged in the trigger cycle so sberror blocks the next request
   assign err_valid_o = accept & (start_err != dm_sba_pkg::ERR_NONE);

   always_comb begin
      if (err_valid_o) begin
         err_code_o = start_err;
      end else begin
         err_code_o = dm_sba_pkg::ERR_NONE;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         dm_sba_pkg::IDLE: begin
            if (accept && start_err == dm_sba_pkg::ERR_NONE) begin
               state_d = dm_sba_pkg::ISSUE;
            end
         end
         dm_sba_pkg::ISSUE: begin
            state_d = dm_sba_pkg::CAPTURE;
         end
         dm_sba_pkg::CAPTURE: begin
            state_d = dm_sba_pkg::IDLE;
         end
         default: begin
            state_d = dm_sba_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         state_q <= dm_sba_pkg::IDLE;
         write_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            write_q <= sba_cmd_i.write;
         end
      end
   end

   assign busy_o        = state_q != dm_sba_pkg::IDLE;
   assign access_done_o = state_q == dm_sba_pkg::CAPTURE;

   // address and data hold steady while busy, only the write strobe is timed
   assign mem_req_o.idx   = word_idx_i;
   assign mem_req_o.we    = (state_q == dm_sba_pkg::ISSUE) & write_q;
   assign mem_req_o.wdata = wdata_i;

   // the register file must hold triggers back while an access runs
   a_start_in_idle: assert property (@(posedge clk_sys) disable iff (reset_i)
      sba_cmd_i.start |-> state_q == dm_sba_pkg::IDLE);

endmodule

/* src/dmi_regfile.sv */
// DMI slave with fixed one-cycle response; master waits for rvalid before the next request
`timescale 1ns/1ns

module dmi_regfile (
   input  logic                           clk_sys,
   input  logic                           reset_i,
   input  logic                           dmi_req_i,
   input  dm_sba_pkg::dmi_req_t           dmi_req_data_i,
   output logic                           dmi_rvalid_o,
   output logic [dm_sba_pkg::DATA_W-1:0]  dmi_rdata_o,
   output dm_sba_pkg::sba_cmd_t           sba_cmd_o,
   output logic                           addr_load_o,
   output logic [dm_sba_pkg::DATA_W-1:0]  addr_wdata_o,
   output dm_sba_pkg::sbcs_t              sbcs_o,
   input  logic [dm_sba_pkg::DATA_W-1:0]  sbaddr_i,
   input  logic                           busy_i,
   input  logic                           access_done_i,
   input  logic [dm_sba_pkg::DATA_W-1:0]  rdata_i,
   input  logic                           err_valid_i,
   input  dm_sba_pkg::sb_err_e            err_code_i
);

   logic                          dmactive_q;
   dm_sba_pkg::sbcs_t             sbcs_q;
   dm_sba_pkg::sbcs_t             sbcs_wr;
   logic [dm_sba_pkg::DATA_W-1:0] sbdata_q;
   logic [dm_sba_pkg::DATA_W-1:0] rd_mux;
   logic [dm_sba_pkg::DATA_W-1:0] rdata_q;
   logic                          rvalid_q;
   dm_sba_pkg::sba_cmd_t          cmd_q;
   logic                          is_write;
   logic                          is_read;
   logic                          hit_dmctl;
   logic                          hit_sbcs;
   logic                          hit_addr;
   logic                          hit_data;
   logic                          busy_eff;
   logic                          want_trig;
   logic                          trig_go;
   logic                          busy_hit;

   assign is_write  = dmi_req_i & dmi_req_data_i.we;
   assign is_read   = dmi_req_i & ~dmi_req_data_i.we;
   assign hit_dmctl = dmi_req_data_i.addr == dm_sba_pkg::DMI_DMCONTROL;
   assign hit_sbcs  = dmi_req_data_i.addr == dm_sba_pkg::DMI_SBCS;
   assign hit_addr  = dmi_req_data_i.addr == dm_sba_pkg::DMI_SBADDRESS0;
   assign hit_data  = dmi_req_data_i.addr == dm_sba_pkg::DMI_SBDATA0;

   // a trigger sitting in cmd_q counts as busy before the sequencer shows it
   assign busy_eff = busy_i | cmd_q.start;

   // writable SBCS fields as they sit in the written word
   assign sbcs_wr = dmi_req_data_i.wdata[dm_sba_pkg::SBCS_LSB +: $bits(dm_sba_pkg::sbcs_t)];

   always_comb begin
      want_trig = (is_write & hit_data) |
                  (is_write & hit_addr & sbcs_q.sbreadonaddr) |
                  (is_read & hit_data & sbcs_q.sbreadondata);
      // gated by dmactive and a clean sberror
      want_trig = want_trig & dmactive_q & (sbcs_q.sberror == dm_sba_pkg::ERR_NONE);
      trig_go   = want_trig & ~busy_eff;
      busy_hit  = (want_trig | (is_write & hit_addr)) & busy_eff;
   end

   assign addr_load_o  = is_write & hit_addr & ~busy_eff;
   assign addr_wdata_o = dmi_req_data_i.wdata;

   always_comb begin
      sbcs_o = sbcs_q;
      sbcs_o.sbbusy = busy_i;
   end

   always_comb begin
      rd_mux = '0;
      case (dmi_req_data_i.addr)
         dm_sba_pkg::DMI_DMCONTROL:  rd_mux = {{(dm_sba_pkg::DATA_W-1){1'b0}}, dmactive_q};
         dm_sba_pkg::DMI_SBCS:       rd_mux = dm_sba_pkg::DATA_W'(sbcs_o) << dm_sba_pkg::SBCS_LSB;
         dm_sba_pkg::DMI_SBADDRESS0: rd_mux = sbaddr_i;
         dm_sba_pkg::DMI_SBDATA0:    rd_mux = sbdata_q;
         default:                    rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         dmactive_q <= 1'b0;
         sbcs_q     <= dm_sba_pkg::SBCS_RST;
         rvalid_q   <= 1'b0;
         cmd_q      <= '0;
      end else begin
         rvalid_q    <= dmi_req_i;
         cmd_q.start <= trig_go;
         // write flag stays put so the capture knows the access kind
         if (trig_go) begin
            cmd_q.write <= is_write & hit_data;
         end
         if (is_write & hit_dmctl) begin
            dmactive_q <= dmi_req_data_i.wdata[0];
         end
         if (is_write & hit_sbcs) begin
            sbcs_q.sbreadonaddr    <= sbcs_wr.sbreadonaddr;
            sbcs_q.sbaccess        <= sbcs_wr.sbaccess;
            sbcs_q.sbautoincrement <= sbcs_wr.sbautoincrement;
            sbcs_q.sbreadondata    <= sbcs_wr.sbreadondata;
            if (sbcs_wr.sbbusyerror) begin
               sbcs_q.sbbusyerror <= 1'b0;
            end
            // any 1 written into sberror clears the whole code
            if (|sbcs_wr.sberror) begin
               sbcs_q.sberror <= dm_sba_pkg::ERR_NONE;
            end
         end
         if (busy_hit) begin
            sbcs_q.sbbusyerror <= 1'b1;
         end
         if (err_valid_i) begin
            sbcs_q.sberror <= err_code_i;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      rdata_q <= is_read ? rd_mux : '0;
      if (access_done_i && !cmd_q.write) begin
         sbdata_q <= rdata_i;
      end else if (is_write && hit_data && !busy_eff) begin
         sbdata_q <= dmi_req_data_i.wdata;
      end
   end

   assign dmi_rvalid_o = rvalid_q;
   assign dmi_rdata_o  = rdata_q;
   assign sba_cmd_o    = cmd_q;

   // the master waits for each response before its next request
   a_rvalid_single: assert property (@(posedge clk_sys) disable iff (reset_i)
      dmi_rvalid_o |=> !dmi_rvalid_o);

endmodule

/* src/sba_top.sv */
// SBA top with a plain DMI strobe port; no TAP or DTM, no back-pressure on requests
`timescale 1ns/1ns

module sba_top (
   input  logic                           clk_sys,
   input  logic                           reset_i,
   input  logic                           dmi_req_i,
   input  dm_sba_pkg::dmi_req_t           dmi_req_data_i,
   output logic                           dmi_rvalid_o,
   output logic [dm_sba_pkg::DATA_W-1:0]  dmi_rdata_o
);

   dm_sba_pkg::sba_cmd_t          sba_cmd;
   dm_sba_pkg::sbcs_t             sbcs;
   dm_sba_pkg::mem_req_t          mem_req;
   dm_sba_pkg::sb_err_e           err_code;
   dm_sba_pkg::sb_err_e           addr_err;
   logic                          addr_load;
   logic [dm_sba_pkg::DATA_W-1:0] addr_wdata;
   logic [dm_sba_pkg::DATA_W-1:0] sbaddr;
   logic [dm_sba_pkg::DATA_W-1:0] sbdata;
   logic [dm_sba_pkg::DATA_W-1:0] mem_rdata;
   logic [dm_sba_pkg::MEM_AW-1:0] word_idx;
   logic                          busy;
   logic                          access_done;
   logic                          err_valid;

   dmi_regfile regfile0 (
      .clk_sys        (clk_sys),
      .reset_i        (reset_i),
      .dmi_req_i      (dmi_req_i),
      .dmi_req_data_i (dmi_req_data_i),
      .dmi_rvalid_o   (dmi_rvalid_o),
      .dmi_rdata_o    (dmi_rdata_o),
      .sba_cmd_o      (sba_cmd),
      .addr_load_o    (addr_load),
      .addr_wdata_o   (addr_wdata),
      .sbcs_o         (sbcs),
      .sbaddr_i       (sbaddr),
      .busy_i         (busy),
      .access_done_i  (access_done),
      .rdata_i        (mem_rdata),
      .err_valid_i    (err_valid),
      .err_code_i     (err_code)
   );

   // bus write data is the stored SBData0 word
   assign sbdata = regfile0.sbdata_q;

   sba_fsm fsm0 (
      .clk_sys        (clk_sys),
      .reset_i        (reset_i),
      .sba_cmd_i      (sba_cmd),
      .sbaccess_i     (sbcs.sbaccess),
      .addr_err_i     (addr_err),
      .word_idx_i     (word_idx),
      .wdata_i        (sbdata),
      .mem_req_o      (mem_req),
      .busy_o         (busy),
      .access_done_o  (access_done),
      .err_valid_o    (err_valid),
      .err_code_o     (err_code)
   );

   sba_addr_counter addr0 (
      .clk_sys        (clk_sys),
      .reset_i        (reset_i),
      .load_i         (addr_load),
      .load_data_i    (addr_wdata),
      .step_i         (access_done),
      .autoinc_i      (sbcs.sbautoincrement),
      .addr_o         (sbaddr),
      .word_idx_o     (word_idx),
      .addr_err_o     (addr_err)
   );

   // memory port stays selected for the whole busy window
   sba_sram sram0 (
      .clk_sys        (clk_sys),
      .mem_req_i      (mem_req),
      .mem_valid_i    (busy),
      .rdata_o        (mem_rdata)
   );

endmodule

/* tests/tb_sba_tasks.svh */
// DMI master tasks and SBCS/memory models; include inside tb_sba_top after its signals
`ifndef TB_SBA_TASKS_SVH
`define TB_SBA_TASKS_SVH

// expected memory contents and SBCS fields
logic [31:0] mem_model [256];
logic        m_busyerror = 1'b0;
logic        m_roa = 1'b0;
logic [2:0]  m_access = 3'd2;
logic        m_autoinc = 1'b0;
logic        m_rod = 1'b0;
logic [2:0]  m_err = 3'd0;

// SBCS word at the standard bit positions 22 down to 12
function automatic logic [31:0] sbcs_expect(input logic busy);
   return {9'd0, m_busyerror, busy, m_roa, m_access, m_autoinc, m_rod, m_err, 12'd0};
endfunction

task automatic fail_value(input string what, input logic [31:0] got, input logic [31:0] exp);
   $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
   value_errors++;
endtask

// one request, the response is due in the very next cycle
task automatic dmi_transfer(input logic [6:0] addr, input logic we, input logic [31:0] wdata,
                            output logic [31:0] rdata);
   @(posedge clk_sys);
   dmi_req <= 1'b1;
   dmi_req_data.addr <= addr;
   dmi_req_data.we <= we;
   dmi_req_data.wdata <= wdata;
   @(posedge clk_sys);
   dmi_req <= 1'b0;
   @(negedge clk_sys);
   rdata = dmi_rdata;
   if (dmi_rvalid !== 1'b1) begin
      $display("DMI response missing one cycle after the request at %0t ns", $time);
      other_errors++;
   end
   if (we && rdata !== 32'd0) begin
      fail_value("write response data", rdata, 32'd0);
   end
endtask

task automatic dmi_write(input logic [6:0] addr, input logic [31:0] wdata);
   logic [31:0] r;
   dmi_transfer(addr, 1'b1, wdata, r);
endtask

task automatic dmi_read(input logic [6:0] addr, output logic [31:0] rdata);
   dmi_transfer(addr, 1'b0, 32'd0, rdata);
endtask

// polls SBCS until sbbusy drops, every other bit must match the model
task automatic wait_not_busy();
   logic [31:0] r;
   int tries;
   tries = 0;
   r = 32'h0020_0000;
   while (r[21] && tries < 8) begin
      dmi_read(dm_sba_pkg::DMI_SBCS, r);
      if ((r & ~32'h0020_0000) !== sbcs_expect(1'b0)) begin
         fail_value("SBCS while polling", r, sbcs_expect(1'b0));
      end
      tries++;
   end
   if (r[21] !== 1'b0) begin
      $display("sbbusy still set after %0d polls at %0t ns", tries, $time);
      other_errors++;
   end
endtask

task automatic set_sbcs(input logic roa, input logic [2:0] access, input logic autoinc,
                        input logic rod, input logic clr_be, input logic clr_err);
   dmi_write(dm_sba_pkg::DMI_SBCS,
             {9'd0, clr_be, 1'b0, roa, access, autoinc, rod, {3{clr_err}}, 12'd0});
   m_roa = roa;
   m_access = access;
   m_autoinc = autoinc;
   m_rod = rod;
   if (clr_be) begin
      m_busyerror = 1'b0;
   end
   if (clr_err) begin
      m_err = 3'd0;
   end
endtask

`endif

/* tests/tb_sba_top.sv */
// random SBA test against memory and SBCS models; expects each DMI response one cycle late
`timescale 1ns/1ns

module tb_sba_top;

   localparam int BURSTS = 3;
   // DMI requests: fill and final readback with polls, bursts of up to 20 words, error cases
   localparam int NUM_OPS = 2 * 256 * 3 + BURSTS * 20 * 6 + 200;
   localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 500;

   logic                 clk_sys = 1'b0;
   logic                 reset_i = 1'b1;
   logic                 dmi_req = 1'b0;
   dm_sba_pkg::dmi_req_t dmi_req_data = '0;
   logic                 dmi_rvalid;
   logic [31:0]          dmi_rdata;
   int                   seed = 97248;
   int                   value_errors = 0;
   int                   other_errors = 0;
   int                   cycle_count = 0;

   `include "tb_sba_tasks.svh"

   sba_top dut0 (
      .clk_sys        (clk_sys),
      .reset_i        (reset_i),
      .dmi_req_i      (dmi_req),
      .dmi_req_data_i (dmi_req_data),
      .dmi_rvalid_o   (dmi_rvalid),
      .dmi_rdata_o    (dmi_rdata)
   );

   always #5 clk_sys = ~clk_sys;

   always @(posedge clk_sys) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run still going after %0d cycles", cycle_count);
         $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors + 1);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_addr(input logic [31:0] exp);
      logic [31:0] r;
      dmi_read(dm_sba_pkg::DMI_SBADDRESS0, r);
      if (r !== exp) fail_value("SBAddress0", r, exp);
   endtask

   // autoincrement on, sbreadonaddr off
   task automatic write_burst(input int start, input int n);
      logic [31:0] w;
      dmi_write(dm_sba_pkg::DMI_SBADDRESS0, 32'(4 * start));
      for (int i = 0; i < n; i++) begin
         w = $random(seed);
         dmi_write(dm_sba_pkg::DMI_SBDATA0, w);
         mem_model[8'(start + i)] = w;
         wait_not_busy();
      end
   endtask

   // readonaddr fetches the first word, readondata the rest; last read fetches nothing
   task automatic readback(input int start, input int n);
      logic [31:0] r;
      set_sbcs(1'b1, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0);
      dmi_write(dm_sba_pkg::DMI_SBADDRESS0, 32'(4 * start));
      wait_not_busy();
      for (int i = 0; i < n; i++) begin
         if (i == n - 1) begin
            set_sbcs(1'b1, 3'd2, 1'b1, 1'b0, 1'b0, 1'b0);
         end
         dmi_read(dm_sba_pkg::DMI_SBDATA0, r);
         if (r !== mem_model[8'(start + i)]) fail_value("SBData0", r, mem_model[8'(start + i)]);
         wait_not_busy();
      end
      set_sbcs(1'b0, 3'd2, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic busy_checks();
      logic [31:0] r;
      logic [31:0] w;
      int p;
      p = {$random(seed)} % 250;
      w = $random(seed);
      dmi_write(dm_sba_pkg::DMI_SBADDRESS0, 32'(4 * p));
      dmi_write(dm_sba_pkg::DMI_SBDATA0, w);
      mem_model[8'(p)] = w;
      dmi_read(dm_sba_pkg::DMI_SBCS, r);
      if (r !== sbcs_expect(1'b1)) fail_value("SBCS right after a write", r, sbcs_expect(1'b1));
      dmi_read(dm_sba_pkg::DMI_SBCS, r);
      if (r !== sbcs_expect(1'b0)) fail_value("SBCS two cycles later", r, sbcs_expect(1'b0));
      // second write lands in the busy window and is dropped
      w = $random(seed);
      dmi_write(dm_sba_pkg::DMI_SBDATA0, w);
      mem_model[8'(p + 1)] = w;
      dmi_write(dm_sba_pkg::DMI_SBDATA0, $random(seed));
      m_busyerror = 1'b1;
      wait_not_busy();
      set_sbcs(1'b0, 3'd2, 1'b1, 1'b0, 1'b1, 1'b0);
      dmi_read(dm_sba_pkg::DMI_SBCS, r);
      if (r !== sbcs_expect(1'b0)) fail_value("SBCS after busy error clear", r, sbcs_expect(1'b0));
      readback(p, 2);
   endtask

   // one faulting access, then a trigger that sberror has to block
   task automatic trigger_error(input logic [31:0] addr, input logic [2:0] access,
                                input logic [2:0] code);
      logic [31:0] r;
      logic [31:0] safe;
      safe = 4 * ({$random(seed)} % 256);
      set_sbcs(1'b0, access, 1'b1, 1'b0, 1'b0, 1'b0);
      dmi_write(dm_sba_pkg::DMI_SBADDRESS0, addr);
      dmi_write(dm_sba_pkg::DMI_SBDATA0, $random(seed));
      m_err = code;
      wait_not_busy();
      dmi_write(dm_sba_pkg::DMI_SBADDRESS0, safe);
      dmi_write(dm_sba_pkg::DMI_SBDATA0, $random(seed));
      // an access that started would show busy here
      dmi_read(dm_sba_pkg::DMI_SBCS, r);
      if (r !== sbcs_expect(1'b0)) fail_value("SBCS with sberror set", r, sbcs_expect(1'b0));
      check_addr(safe);
      set_sbcs(1'b0, 3'd2, 1'b1, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic dmactive_off();
      logic [31:0] r;
      logic [31:0] a;
      a = 4 * ({$random(seed)} % 256);
      dmi_write(dm_sba_pkg::DMI_DMCONTROL, 32'd0);
      dmi_read(dm_sba_pkg::DMI_DMCONTROL, r);
      if (r !== 32'd0) fail_value("DMControl", r, 32'd0);
      dmi_write(dm_sba_pkg::DMI_SBADDRESS0, a);
      repeat (3) begin
         dmi_write(dm_sba_pkg::DMI_SBDATA0, $random(seed));
         dmi_read(dm_sba_pkg::DMI_SBCS, r);
         if (r !== sbcs_expect(1'b0)) fail_value("SBCS with dmactive low", r, sbcs_expect(1'b0));
      end
      check_addr(a);
      dmi_write(dm_sba_pkg::DMI_DMCONTROL, 32'd1);
   endtask

   initial begin
      logic [31:0] r;
      int start;
      int n;
      logic [2:0] bad_size;
      repeat (8) @(posedge clk_sys);
      reset_i <= 1'b0;
      dmi_read(dm_sba_pkg::DMI_SBCS, r);
      if (r !== sbcs_expect(1'b0)) fail_value("SBCS after reset", r, sbcs_expect(1'b0));
      dmi_read(7'h20, r);
      if (r !== 32'd0) fail_value("unmapped register", r, 32'd0);
      dmi_write(dm_sba_pkg::DMI_DMCONTROL, 32'd1);
      set_sbcs(1'b0, 3'd2, 1'b1, 1'b0, 1'b0, 1'b0);
      // whole memory gets known contents first
      write_burst(0, 256);
      check_addr(32'd1024);
      for (int b = 0; b < BURSTS; b++) begin
         start = {$random(seed)} % 200;
         n = 4 + {$random(seed)} % 16;
         write_burst(start, n);
         check_addr(32'(4 * (start + n)));
         readback(start, n);
         check_addr(32'(4 * (start + n)));
      end
      busy_checks();
      trigger_error(4 * ({$random(seed)} % 256) + 1 + {$random(seed)} % 3, 3'd2, 3'd3);
      trigger_error(32'h400 + 4 * ({$random(seed)} % 1024), 3'd2, 3'd2);
      bad_size = 3'({$random(seed)} % 8);
      if (bad_size == 3'd2) begin
         bad_size = 3'd5;
      end
      trigger_error(4 * ({$random(seed)} % 256), bad_size, 3'd4);
      dmactive_off();
      readback(0, 256);
      check_addr(32'd1024);
      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* src.f */
+incdir+tests
src/dm_sba_pkg.sv
src/sba_sram.sv
src/sba_addr_counter.sv
src/sba_fsm.sv
src/dmi_regfile.sv
src/sba_top.sv
tests/tb_sba_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_sba_top
FILELIST = src.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
